// File: verilog/common_pkg.sv
`default_nettype none

package common_pkg;

    // data word carried by operands and result buses
    typedef logic [31:0] word_t;

    // physical register tag, tag 0 is never woken
    typedef logic [5:0] preg_t;

    // alu opcode, the multiplier ignores it
    typedef logic [1:0] op_t;

    localparam op_t OP_ADD = 2'd0;
    localparam op_t OP_SUB = 2'd1;
    localparam op_t OP_AND = 2'd2;
    localparam op_t OP_XOR = 2'd3;

endpackage

`default_nettype wire

// File: verilog/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // which queue a dispatched op belongs to
    typedef logic [0:0] iq_class_t;

    localparam iq_class_t CLASS_ALU = 1'b0;
    localparam iq_class_t CLASS_MUL = 1'b1;

    // dispatch lanes per cycle
    localparam int WRITE_NUM = 2;

    // result buses fed back as wakeups
    localparam int WAKE_NUM = 2;

    // bus index of each unit
    localparam int WAKE_ALU = 0;
    localparam int WAKE_MUL = 1;

    // default queue depths
    localparam int ALU_QUEUE_LEN = 8;
    localparam int MUL_QUEUE_LEN = 4;

endpackage

`default_nettype wire

// File: verilog/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue
    import common_pkg::*;
    import issue_pkg::*;
#(
    parameter int        QUEUE_LEN   = ALU_QUEUE_LEN,
    parameter iq_class_t QUEUE_CLASS = CLASS_ALU,
    parameter int        READ_NUM    = 1
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,

    input  logic      [WRITE_NUM-1:0]  disp_valid,
    input  iq_class_t [WRITE_NUM-1:0]  disp_class,
    input  op_t       [WRITE_NUM-1:0]  disp_op,
    input  preg_t     [WRITE_NUM-1:0]  disp_dest,
    input  preg_t     [WRITE_NUM-1:0]  disp_src1_tag,
    input  logic      [WRITE_NUM-1:0]  disp_src1_ready,
    input  word_t     [WRITE_NUM-1:0]  disp_src1_data,
    input  preg_t     [WRITE_NUM-1:0]  disp_src2_tag,
    input  logic      [WRITE_NUM-1:0]  disp_src2_ready,
    input  word_t     [WRITE_NUM-1:0]  disp_src2_data,

    input  logic      [WAKE_NUM-1:0]   wake_valid,
    input  preg_t     [WAKE_NUM-1:0]   wake_tag,
    input  word_t     [WAKE_NUM-1:0]   wake_data,

    output logic      [READ_NUM-1:0]   iss_valid,
    output op_t       [READ_NUM-1:0]   iss_op,
    output preg_t     [READ_NUM-1:0]   iss_dest,
    output word_t     [READ_NUM-1:0]   iss_a,
    output word_t     [READ_NUM-1:0]   iss_b,

    output logic                       full
);

    localparam int CNT_W   = $clog2(QUEUE_LEN + 1);
    localparam int FULL_AT = QUEUE_LEN - WRITE_NUM;

    // entry storage, valid below cnt, oldest at index 0
    op_t   e_op      [QUEUE_LEN];
    preg_t e_dest    [QUEUE_LEN];
    preg_t e_s1_tag  [QUEUE_LEN];
    preg_t e_s2_tag  [QUEUE_LEN];
    word_t e_s1_data [QUEUE_LEN];
    word_t e_s2_data [QUEUE_LEN];
    logic [QUEUE_LEN-1:0] e_s1_rdy;
    logic [QUEUE_LEN-1:0] e_s2_rdy;
    logic [CNT_W-1:0] cnt;

    // entries after this cycle's wakes
    word_t w_s1_data [QUEUE_LEN];
    word_t w_s2_data [QUEUE_LEN];
    logic [QUEUE_LEN-1:0] w_s1_rdy;
    logic [QUEUE_LEN-1:0] w_s2_rdy;

    // incoming lanes after wakes
    word_t [WRITE_NUM-1:0] in_s1_data;
    word_t [WRITE_NUM-1:0] in_s2_data;
    logic  [WRITE_NUM-1:0] in_s1_rdy;
    logic  [WRITE_NUM-1:0] in_s2_rdy;

    // next state
    op_t   n_op      [QUEUE_LEN];
    preg_t n_dest    [QUEUE_LEN];
    preg_t n_s1_tag  [QUEUE_LEN];
    preg_t n_s2_tag  [QUEUE_LEN];
    word_t n_s1_data [QUEUE_LEN];
    word_t n_s2_data [QUEUE_LEN];
    logic [QUEUE_LEN-1:0] n_s1_rdy;
    logic [QUEUE_LEN-1:0] n_s2_rdy;
    logic [CNT_W-1:0] cnt_nxt;

    assign full = int'(cnt) > FULL_AT;

    // tag match, each source captures its own data
    always_comb begin
        for (int i = 0; i < QUEUE_LEN; i++) begin
            w_s1_rdy[i]  = e_s1_rdy[i];
            w_s2_rdy[i]  = e_s2_rdy[i];
            w_s1_data[i] = e_s1_data[i];
            w_s2_data[i] = e_s2_data[i];
            for (int w = 0; w < WAKE_NUM; w++) begin
                if (wake_valid[w] && !e_s1_rdy[i] && wake_tag[w] == e_s1_tag[i]) begin
                    w_s1_rdy[i]  = 1'b1;
                    w_s1_data[i] = wake_data[w];
                end
                if (wake_valid[w] && !e_s2_rdy[i] && wake_tag[w] == e_s2_tag[i]) begin
                    w_s2_rdy[i]  = 1'b1;
                    w_s2_data[i] = wake_data[w];
                end
            end
        end
        for (int l = 0; l < WRITE_NUM; l++) begin
            in_s1_rdy[l]  = disp_src1_ready[l];
            in_s2_rdy[l]  = disp_src2_ready[l];
            in_s1_data[l] = disp_src1_data[l];
            in_s2_data[l] = disp_src2_data[l];
            for (int w = 0; w < WAKE_NUM; w++) begin
                if (wake_valid[w] && !disp_src1_ready[l] &&
                    wake_tag[w] == disp_src1_tag[l]) begin
                    in_s1_rdy[l]  = 1'b1;
                    in_s1_data[l] = wake_data[w];
                end
                if (wake_valid[w] && !disp_src2_ready[l] &&
                    wake_tag[w] == disp_src2_tag[l]) begin
                    in_s2_rdy[l]  = 1'b1;
                    in_s2_data[l] = wake_data[w];
                end
            end
        end
    end

    // select oldest ready, compact the rest, then bypass or append writes
    always_comb begin
        int k;
        int nsel;
        k    = 0;
        nsel = 0;
        iss_valid = '0;
        iss_op    = '0;
        iss_dest  = '0;
        iss_a     = '0;
        iss_b     = '0;
        n_op      = e_op;
        n_dest    = e_dest;
        n_s1_tag  = e_s1_tag;
        n_s2_tag  = e_s2_tag;
        n_s1_data = w_s1_data;
        n_s2_data = w_s2_data;
        n_s1_rdy  = w_s1_rdy;
        n_s2_rdy  = w_s2_rdy;

        for (int i = 0; i < QUEUE_LEN; i++) begin
            if (i < int'(cnt)) begin
                if (w_s1_rdy[i] && w_s2_rdy[i] && nsel < READ_NUM) begin
                    iss_valid[nsel] = 1'b1;
                    iss_op[nsel]    = e_op[i];
                    iss_dest[nsel]  = e_dest[i];
                    iss_a[nsel]     = w_s1_data[i];
                    iss_b[nsel]     = w_s2_data[i];
                    nsel = nsel + 1;
                end else begin
                    n_op[k]      = e_op[i];
                    n_dest[k]    = e_dest[i];
                    n_s1_tag[k]  = e_s1_tag[i];
                    n_s2_tag[k]  = e_s2_tag[i];
                    n_s1_data[k] = w_s1_data[i];
                    n_s2_data[k] = w_s2_data[i];
                    n_s1_rdy[k]  = w_s1_rdy[i];
                    n_s2_rdy[k]  = w_s2_rdy[i];
                    k = k + 1;
                end
            end
        end

        // lane 0 is older than lane 1
        for (int l = 0; l < WRITE_NUM; l++) begin
            if (disp_valid[l] && disp_class[l] == QUEUE_CLASS) begin
                if (in_s1_rdy[l] && in_s2_rdy[l] && nsel < READ_NUM) begin
                    iss_valid[nsel] = 1'b1;
                    iss_op[nsel]    = disp_op[l];
                    iss_dest[nsel]  = disp_dest[l];
                    iss_a[nsel]     = in_s1_data[l];
                    iss_b[nsel]     = in_s2_data[l];
                    nsel = nsel + 1;
                end else if (k < QUEUE_LEN) begin
                    n_op[k]      = disp_op[l];
                    n_dest[k]    = disp_dest[l];
                    n_s1_tag[k]  = disp_src1_tag[l];
                    n_s2_tag[k]  = disp_src2_tag[l];
                    n_s1_data[k] = in_s1_data[l];
                    n_s2_data[k] = in_s2_data[l];
                    n_s1_rdy[k]  = in_s1_rdy[l];
                    n_s2_rdy[k]  = in_s2_rdy[l];
                    k = k + 1;
                end
            end
        end
        cnt_nxt = CNT_W'(k);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (flush) begin
            cnt <= '0;
        end else begin
            cnt <= cnt_nxt;
        end
    end

    // contents only matter below cnt
    always_ff @(posedge clk) begin
        e_op      <= n_op;
        e_dest    <= n_dest;
        e_s1_tag  <= n_s1_tag;
        e_s2_tag  <= n_s2_tag;
        e_s1_data <= n_s1_data;
        e_s2_data <= n_s2_data;
        e_s1_rdy  <= n_s1_rdy;
        e_s2_rdy  <= n_s2_rdy;
    end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import common_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,

    input  logic  iss_valid,
    input  op_t   iss_op,
    input  preg_t iss_dest,
    input  word_t iss_a,
    input  word_t iss_b,

    output logic  res_valid,
    output preg_t res_tag,
    output word_t res_data
);

    word_t result;

    always_comb begin
        case (iss_op)
            OP_ADD:  result = iss_a + iss_b;
            OP_SUB:  result = iss_a - iss_b;
            OP_AND:  result = iss_a & iss_b;
            default: result = iss_a ^ iss_b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (flush) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= iss_valid;
        end
    end

    // tag and data only move with a valid op
    always_ff @(posedge clk) begin
        if (iss_valid) begin
            res_tag  <= iss_dest;
            res_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import common_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,

    input  logic  iss_valid,
    input  preg_t iss_dest,
    input  word_t iss_a,
    input  word_t iss_b,

    output logic  res_valid,
    output preg_t res_tag,
    output word_t res_data
);

    // stage one holds operands and tag
    logic  s1_valid;
    preg_t s1_tag;
    word_t s1_a;
    word_t s1_b;

    // low half of the product
    word_t prod_lo;

    assign prod_lo = s1_a * s1_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else if (flush) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= iss_valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            s1_tag <= iss_dest;
            s1_a   <= iss_a;
            s1_b   <= iss_b;
        end
        if (s1_valid) begin
            res_tag  <= s1_tag;
            res_data <= prod_lo;
        end
    end

endmodule

`default_nettype wire

// File: verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage
    import common_pkg::*;
    import issue_pkg::*;
#(
    parameter int ALU_LEN = ALU_QUEUE_LEN,
    parameter int MUL_LEN = MUL_QUEUE_LEN
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,

    input  logic      [WRITE_NUM-1:0]  disp_valid,
    input  iq_class_t [WRITE_NUM-1:0]  disp_class,
    input  op_t       [WRITE_NUM-1:0]  disp_op,
    input  preg_t     [WRITE_NUM-1:0]  disp_dest,
    input  preg_t     [WRITE_NUM-1:0]  disp_src1_tag,
    input  logic      [WRITE_NUM-1:0]  disp_src1_ready,
    input  word_t     [WRITE_NUM-1:0]  disp_src1_data,
    input  preg_t     [WRITE_NUM-1:0]  disp_src2_tag,
    input  logic      [WRITE_NUM-1:0]  disp_src2_ready,
    input  word_t     [WRITE_NUM-1:0]  disp_src2_data,

    output logic                       alu_full,
    output logic                       mul_full,

    output logic      [WAKE_NUM-1:0]   res_valid,
    output preg_t     [WAKE_NUM-1:0]   res_tag,
    output word_t     [WAKE_NUM-1:0]   res_data
);

    // one issue slot per queue
    localparam int ISSUE_READ = 1;

    logic  [ISSUE_READ-1:0] alu_iss_valid;
    op_t   [ISSUE_READ-1:0] alu_iss_op;
    preg_t [ISSUE_READ-1:0] alu_iss_dest;
    word_t [ISSUE_READ-1:0] alu_iss_a;
    word_t [ISSUE_READ-1:0] alu_iss_b;

    logic  [ISSUE_READ-1:0] mul_iss_valid;
    preg_t [ISSUE_READ-1:0] mul_iss_dest;
    word_t [ISSUE_READ-1:0] mul_iss_a;
    word_t [ISSUE_READ-1:0] mul_iss_b;

    logic  alu_res_valid;
    preg_t alu_res_tag;
    word_t alu_res_data;
    logic  mul_res_valid;
    preg_t mul_res_tag;
    word_t mul_res_data;

    logic  [WAKE_NUM-1:0] wake_valid;
    preg_t [WAKE_NUM-1:0] wake_tag;
    word_t [WAKE_NUM-1:0] wake_data;

    // result buses close the wakeup loop
    assign wake_valid[WAKE_ALU] = alu_res_valid;
    assign wake_tag[WAKE_ALU]   = alu_res_tag;
    assign wake_data[WAKE_ALU]  = alu_res_data;
    assign wake_valid[WAKE_MUL] = mul_res_valid;
    assign wake_tag[WAKE_MUL]   = mul_res_tag;
    assign wake_data[WAKE_MUL]  = mul_res_data;

    assign res_valid = wake_valid;
    assign res_tag   = wake_tag;
    assign res_data  = wake_data;

    issue_queue #(
        .QUEUE_LEN   (ALU_LEN),
        .QUEUE_CLASS (CLASS_ALU),
        .READ_NUM    (ISSUE_READ)
    ) u_alu_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .disp_valid      (disp_valid),
        .disp_class      (disp_class),
        .disp_op         (disp_op),
        .disp_dest       (disp_dest),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src1_ready (disp_src1_ready),
        .disp_src1_data  (disp_src1_data),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src2_ready (disp_src2_ready),
        .disp_src2_data  (disp_src2_data),
        .wake_valid      (wake_valid),
        .wake_tag        (wake_tag),
        .wake_data       (wake_data),
        .iss_valid       (alu_iss_valid),
        .iss_op          (alu_iss_op),
        .iss_dest        (alu_iss_dest),
        .iss_a           (alu_iss_a),
        .iss_b           (alu_iss_b),
        .full            (alu_full)
    );

    // opcode on the mul lane carries no meaning
    issue_queue #(
        .QUEUE_LEN   (MUL_LEN),
        .QUEUE_CLASS (CLASS_MUL),
        .READ_NUM    (ISSUE_READ)
    ) u_mul_queue (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .disp_valid      (disp_valid),
        .disp_class      (disp_class),
        .disp_op         (disp_op),
        .disp_dest       (disp_dest),
        .disp_src1_tag   (disp_src1_tag),
        .disp_src1_ready (disp_src1_ready),
        .disp_src1_data  (disp_src1_data),
        .disp_src2_tag   (disp_src2_tag),
        .disp_src2_ready (disp_src2_ready),
        .disp_src2_data  (disp_src2_data),
        .wake_valid      (wake_valid),
        .wake_tag        (wake_tag),
        .wake_data       (wake_data),
        .iss_valid       (mul_iss_valid),
        .iss_op          (),
        .iss_dest        (mul_iss_dest),
        .iss_a           (mul_iss_a),
        .iss_b           (mul_iss_b),
        .full            (mul_full)
    );

    alu_unit u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .iss_valid (alu_iss_valid[0]),
        .iss_op    (alu_iss_op[0]),
        .iss_dest  (alu_iss_dest[0]),
        .iss_a     (alu_iss_a[0]),
        .iss_b     (alu_iss_b[0]),
        .res_valid (alu_res_valid),
        .res_tag   (alu_res_tag),
        .res_data  (alu_res_data)
    );

    mul_unit u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .iss_valid (mul_iss_valid[0]),
        .iss_dest  (mul_iss_dest[0]),
        .iss_a     (mul_iss_a[0]),
        .iss_b     (mul_iss_b[0]),
        .res_valid (mul_res_valid),
        .res_tag   (mul_res_tag),
        .res_data  (mul_res_data)
    );

endmodule

`default_nettype wire

// File: tb/issue_checker.sv
`timescale 1ns/1ps
`default_nettype none

module issue_checker
    import common_pkg::*;
    import issue_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic  [WAKE_NUM-1:0]     res_valid,
    input  preg_t [WAKE_NUM-1:0]     res_tag,
    input  word_t [WAKE_NUM-1:0]     res_data,
    input  logic                     mul_full,
    input  logic  [63:0]             exp_known,
    input  logic  [63:0]             exp_mul,
    input  word_t                    exp_data [64],
    input  logic                     run_done,
    output int                       value_errors,
    output int                       other_errors
);

    logic [63:0] seen;
    logic        saw_mul_full;
    logic        scanned;

    always @(posedge clk) begin
        int    want;
        preg_t t;
        if (!rst_n) begin
            seen = '0;
            saw_mul_full = 1'b0;
            scanned = 1'b0;
            value_errors = 0;
            other_errors = 0;
        end else begin
            if (mul_full) begin
                saw_mul_full = 1'b1;
            end
            for (int b = 0; b < WAKE_NUM; b++) begin
                if (res_valid[b]) begin
                    t = res_tag[b];
                    want = exp_mul[t] ? WAKE_MUL : WAKE_ALU;
                    if (!exp_known[t]) begin
                        $display("unexpected tag %h on result bus %0d", t, b);
                        other_errors++;
                    end else if (seen[t]) begin
                        $display("tag %h delivered a second time on bus %0d", t, b);
                        other_errors++;
                    end else begin
                        seen[t] = 1'b1;
                        if (want != b) begin
                            $display("tag %h came out on bus %0d instead of %0d", t, b, want);
                            other_errors++;
                        end
                        if (res_data[b] !== exp_data[t]) begin
                            $display("FAIL res_data[%0d] tag %h: got %h, expected %h",
                                     b, t, res_data[b], exp_data[t]);
                            value_errors++;
                        end
                    end
                end
            end
            // end of run sweep
            if (run_done && !scanned) begin
                scanned = 1'b1;
                for (int i = 0; i < 64; i++) begin
                    if (exp_known[i] && !seen[i]) begin
                        $display("tag %h never appeared on a result bus", i[5:0]);
                        other_errors++;
                    end
                end
                if (!saw_mul_full) begin
                    $display("mul queue never reported full during the run");
                    other_errors++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/issue_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage_sva
    import issue_pkg::*;
(
    input logic                       clk,
    input logic                       rst_n,
    input logic                       flush,
    input logic      [WRITE_NUM-1:0]  disp_valid,
    input iq_class_t [WRITE_NUM-1:0]  disp_class,
    input logic                       alu_full,
    input logic                       mul_full,
    input logic      [WAKE_NUM-1:0]   res_valid
);

    logic [WRITE_NUM-1:0] alu_write;
    logic [WRITE_NUM-1:0] mul_write;

    // set by the first dispatch after reset
    logic disp_seen;

    always_comb begin
        for (int l = 0; l < WRITE_NUM; l++) begin
            alu_write[l] = disp_valid[l] && disp_class[l] == CLASS_ALU;
            mul_write[l] = disp_valid[l] && disp_class[l] == CLASS_MUL;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            disp_seen <= 1'b0;
        end else if (disp_valid != '0) begin
            disp_seen <= 1'b1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !disp_seen |-> (res_valid == '0 && !alu_full && !mul_full))
        else $error("result bus or full level active before the first dispatch");

    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> res_valid == '0)
        else $error("result bus active in the cycle after flush");

    a_alu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        alu_full |-> alu_write == '0)
        else $error("alu write sent while alu queue full");

    a_mul_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mul_full |-> mul_write == '0)
        else $error("mul write sent while mul queue full");

endmodule

bind issue_stage issue_stage_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .disp_valid (disp_valid),
    .disp_class (disp_class),
    .alu_full   (alu_full),
    .mul_full   (mul_full),
    .res_valid  (res_valid)
);

`default_nettype wire

// File: tb/tb_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_stage
    import common_pkg::*;
    import issue_pkg::*;
();

    localparam int N_ROWS      = 28;
    localparam int ROW_W       = 136;
    localparam int CYCLE_LIMIT = 4 * N_ROWS + 50;
    localparam int FLUSH_AT    = 20;

    logic clk;
    logic rst_n;
    logic flush;
    logic      [WRITE_NUM-1:0] disp_valid;
    iq_class_t [WRITE_NUM-1:0] disp_class;
    op_t       [WRITE_NUM-1:0] disp_op;
    preg_t     [WRITE_NUM-1:0] disp_dest;
    preg_t     [WRITE_NUM-1:0] disp_src1_tag;
    logic      [WRITE_NUM-1:0] disp_src1_ready;
    word_t     [WRITE_NUM-1:0] disp_src1_data;
    preg_t     [WRITE_NUM-1:0] disp_src2_tag;
    logic      [WRITE_NUM-1:0] disp_src2_ready;
    word_t     [WRITE_NUM-1:0] disp_src2_data;
    logic alu_full;
    logic mul_full;
    logic  [WAKE_NUM-1:0] res_valid;
    preg_t [WAKE_NUM-1:0] res_tag;
    word_t [WAKE_NUM-1:0] res_data;

    // golden rows and per-tag expectations
    logic [ROW_W-1:0] rows [N_ROWS];
    logic [63:0] exp_known;
    logic [63:0] exp_mul;
    word_t exp_data [64];

    logic [63:0] done;
    logic [31:0] lcg_state;
    logic run_done;
    logic verdict;
    logic flushed;
    int ptr;
    int value_errors;
    int other_errors;

    issue_stage UUT (.*);

    issue_checker chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_valid    (res_valid),
        .res_tag      (res_tag),
        .res_data     (res_data),
        .mul_full     (mul_full),
        .exp_known    (exp_known),
        .exp_mul      (exp_mul),
        .exp_data     (exp_data),
        .run_done     (run_done),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    always #10 clk = ~clk;

    // tags delivered so far, acts as a register file for late consumers
    always @(posedge clk) begin
        if (!rst_n) begin
            done <= '0;
        end else begin
            for (int b = 0; b < WAKE_NUM; b++) begin
                if (res_valid[b]) begin
                    done[res_tag[b]] <= 1'b1;
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic all_done();
        return (done & exp_known) == exp_known;
    endfunction

    function automatic logic class_full(input iq_class_t c);
        return (c == CLASS_MUL) ? mul_full : alu_full;
    endfunction

    task automatic clear_lanes();
        disp_valid      = '0;
        disp_class      = '0;
        disp_op         = '0;
        disp_dest       = '0;
        disp_src1_tag   = '0;
        disp_src1_ready = '0;
        disp_src1_data  = '0;
        disp_src2_tag   = '0;
        disp_src2_ready = '0;
        disp_src2_data  = '0;
    endtask

    task automatic load_lane(input int lane, input int r);
        logic [ROW_W-1:0] row;
        preg_t t1;
        preg_t t2;
        row = rows[r];
        t1  = row[117:112];
        t2  = row[73:68];
        disp_valid[lane]      = 1'b1;
        disp_class[lane]      = row[132];
        disp_op[lane]         = row[129:128];
        disp_dest[lane]       = row[125:120];
        disp_src1_tag[lane]   = t1;
        disp_src1_ready[lane] = row[108];
        disp_src1_data[lane]  = row[107:76];
        disp_src2_tag[lane]   = t2;
        disp_src2_ready[lane] = row[64];
        disp_src2_data[lane]  = row[63:32];
        // producer already broadcast, hand over its value
        if (!row[108] && done[t1]) begin
            disp_src1_ready[lane] = 1'b1;
            disp_src1_data[lane]  = exp_data[t1];
        end
        if (!row[64] && done[t2]) begin
            disp_src2_ready[lane] = 1'b1;
            disp_src2_data[lane]  = exp_data[t2];
        end
    endtask

    task automatic dispatch_cycle();
        int lanes;
        int sent;
        lcg_state = lcg_next(lcg_state);
        if (lcg_state[31:29] == 3'd0) begin
            lanes = 0;
        end else if (lcg_state[28:27] == 2'd0) begin
            lanes = 1;
        end else begin
            lanes = 2;
        end
        sent = 0;
        while (sent < lanes && ptr < N_ROWS) begin
            if (done[rows[ptr][125:120]]) begin
                ptr++;
            end else if (class_full(rows[ptr][132])) begin
                break;
            end else begin
                load_lane(sent, ptr);
                ptr++;
                sent++;
            end
        end
    endtask

    initial begin
        preg_t t;
        clk       = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        run_done  = 1'b0;
        verdict   = 1'b0;
        flushed   = 1'b0;
        ptr       = 0;
        lcg_state = 32'h03c0fe75;
        exp_known = '0;
        exp_mul   = '0;
        clear_lanes();
        for (int i = 0; i < 64; i++) begin
            exp_data[i] = '0;
        end
        $readmemh("tb/issue_golden.txt", rows);
        for (int r = 0; r < N_ROWS; r++) begin
            t = rows[r][125:120];
            exp_known[t] = 1'b1;
            exp_mul[t]   = rows[r][132];
            exp_data[t]  = rows[r][31:0];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (!all_done()) begin
            @(negedge clk);
            clear_lanes();
            flush = 1'b0;
            // one flush, then resend whatever was lost
            if (!flushed && ptr >= FLUSH_AT) begin
                flush   = 1'b1;
                flushed = 1'b1;
                ptr     = 0;
            end else begin
                dispatch_cycle();
            end
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        run_done = 1'b1;
        @(posedge clk);
        @(negedge clk);
        $display("errors: value %0d, other %0d", value_errors, other_errors);
        verdict = 1'b1;
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int n;
        n = 0;
        @(posedge rst_n);
        while (n < CYCLE_LIMIT) begin
            @(posedge clk);
            n++;
        end
        $display("timeout: %0d tags still missing after %0d cycles",
                 $countones(exp_known & ~done), CYCLE_LIMIT);
        verdict = 1'b1;
        $display("** FAIL **");
        $finish;
    end

    // a run stopped by an assertion ends here without a verdict
    final begin
        if (!verdict) begin
            $display("** FAIL **");
        end
    end

endmodule

`default_nettype wire

// File: tb/issue_golden.txt
// class_op_dest_src1tag_src1rdy_src1data_src2tag_src2rdy_src2data_expected
// class 0 alu 1 mul, op 0 add 1 sub 2 and 3 xor, a not-ready source names its producer tag
0_0_01_00_1_00000005_00_1_00000003_00000008
0_1_02_00_1_00000014_00_1_00000006_0000000e
1_0_03_00_1_00000007_00_1_00000009_0000003f
0_2_04_00_1_000000ff_00_1_0000003c_0000003c
0_3_05_00_1_000000aa_00_1_0000000f_000000a5
1_0_06_00_1_00000100_00_1_00000010_00001000
0_0_07_01_0_00000000_00_1_00000002_0000000a
1_0_08_00_1_00000003_07_0_00000000_0000001e
0_1_09_08_0_00000000_03_0_00000000_ffffffdf
0_3_0a_09_0_00000000_00_1_ffffffff_00000020
1_0_0b_0a_0_00000000_06_0_00000000_00020000
1_0_0c_0b_0_00000000_00_1_00000002_00040000
1_0_0d_00_1_00000003_0b_0_00000000_00060000
1_0_0e_0b_0_00000000_00_1_00000010_00200000
1_0_0f_0c_0_00000000_00_1_00000004_00100000
0_0_10_0d_0_00000000_0e_0_00000000_00260000
0_2_11_00_1_12345678_00_1_0f0f0f0f_02040608
1_0_12_00_1_00001234_00_1_00000010_00012340
0_3_13_11_0_00000000_00_1_02040608_00000000
0_1_14_00_1_00000100_00_1_00000001_000000ff
1_0_15_14_0_00000000_12_0_00000000_01221cc0
0_0_16_15_0_00000000_00_1_00000001_01221cc1
1_0_17_16_0_00000000_00_1_00000002_02443982
0_3_18_17_0_00000000_10_0_00000000_02623982
0_2_19_00_1_ffff0000_00_1_00ffff00_00ff0000
1_0_1a_00_1_ffffffff_00_1_ffffffff_00000001
0_1_1b_1a_0_00000000_19_0_00000000_ff010001
1_0_1c_1b_0_00000000_0f_0_00000000_00100000

// File: vlog.f
verilog/common_pkg.sv
verilog/issue_pkg.sv
verilog/issue_queue.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/issue_stage.sv
tb/issue_checker.sv
tb/issue_stage_sva.sv
tb/tb_issue_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_issue_stage -f vlog.f \
    -Mdir obj_dir -o sim_issue_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_issue_stage > sim.log 2>&1
run_status=$?
cat sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    exit 0
fi
echo "simulation failed (exit status ${run_status})"
exit 1
